// File: run.sh
#!/bin/sh
# builds the posit adder testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f vlog.f --top-module positAdderTb --Mdir obj_dir
then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/VpositAdderTb)
status=$?
echo "$output"

if [ "$status" -ne 0 ]
then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "RESULT: PASS"
then
    exit 0
fi
exit 1

// File: source/addSubtract.sv
// posit add/subtract core with ordering, alignment, normalization and scale update
`timescale 1ns/1ns

module addSubtract
(
    input  logic subtract,
    input  positFieldsPkg::decodedPosit_t a,
    input  positFieldsPkg::decodedPosit_t b,
    output positFieldsPkg::rawResult_t raw
);
    import positConfigPkg::*;
    import positFieldsPkg::*;

    // b sign after the subtract flip
    logic effSignB;
    logic effAdd;
    logic aLarger;
    decodedPosit_t largeOp;
    decodedPosit_t smallOp;
    scale_t largeScale;
    scale_t smallScale;
    scale_t scaleDiff;
    logic [scaleWidth:0] alignShift;
    // small fraction followed by room for the shifted-out bits
    logic [3*positWidth-1:0] alignBuf;
    logic [2*positWidth-1:0] smallAligned;
    wideMant_t largeWide;
    wideMant_t sum;
    logic overflow;
    logic [positWidth-1:0] window;
    regime_t shift;

    leadingBitDetector lbd (.window(window), .shift(shift));

    ////////////////////////////////////////////////////////////
    // operand ordering and alignment
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        effSignB = b.sign ^ subtract;
        // same signs add
        effAdd = (a.sign == effSignB);
        // ties go to b
        aLarger = (a.magnitude > b.magnitude);
        largeOp = aLarger ? a : b;
        smallOp = aLarger ? b : a;

        // concatenation forms 2k + e
        largeScale = scale_t'($signed({largeOp.regime, largeOp.exponent}));
        smallScale = scale_t'($signed({smallOp.regime, smallOp.exponent}));
        scaleDiff = largeScale - smallScale;

        // shifts past 2N leave only the sticky bit
        if (scaleDiff > 2 * positWidth)
            alignShift = (scaleWidth + 1)'(2 * positWidth);
        else
            alignShift = scaleDiff[scaleWidth:0];

        alignBuf = {smallOp.fraction, {(2*positWidth){1'b0}}} >> alignShift;
        // everything below the kept bits folds into the lsb
        smallAligned = {alignBuf[3*positWidth-1:positWidth+1], |alignBuf[positWidth:0]};
    end

    ////////////////////////////////////////////////////////////
    // add or subtract, then normalize
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        largeWide = {1'b0, largeOp.fraction, {positWidth{1'b0}}};
        if (effAdd)
            sum = largeWide + wideMant_t'(smallAligned);
        else
            sum = largeWide - wideMant_t'(smallAligned);
        overflow = sum[2*positWidth];

        // overflow folded into the bit below for the detector
        window = {sum[2*positWidth] | sum[2*positWidth-1], sum[2*positWidth-2:positWidth]};

        // carry case drops one bit at the bottom
        if (overflow)
            raw.mantissa = sum[2*positWidth:1] << shift;
        else
            raw.mantissa = sum[2*positWidth-1:0] << shift;
        raw.sticky = overflow & sum[0];

        // larger operand's scale bumped on carry and lowered by the shift
        raw.scale = largeScale + scale_t'(overflow) - scale_t'(shift);
        raw.sign = aLarger ? a.sign : effSignB;

        // a zero operand aligns to nothing and the other one passes
        raw.isNaR = a.isNaR | b.isNaR;
        // exact cancellation or zero plus zero
        raw.isZero = ~raw.isNaR & (sum == '0);
    end

endmodule

// File: source/leadingBitDetector.sv
// leading-one detector giving the normalization left shift
`timescale 1ns/1ns

module leadingBitDetector
(
    input  logic [positConfigPkg::positWidth-1:0] window,
    output positConfigPkg::regime_t shift
);
    import positConfigPkg::*;

    ////////////////////////////////////////////////////////////
    // priority search
    ////////////////////////////////////////////////////////////
    // scan upward so the highest set bit wins
    // all-zero window leaves the shift at zero
    always_comb
    begin
        shift = '0;
        for (int i = 0; i < positWidth; i++)
        begin
            if (window[i])
                shift = regime_t'(positWidth - 1 - i);
        end
    end

    // shift of zero means the msb is already set
    // a window of one lone lsb asks for the full positWidth-1
    // anything past that is an exact cancellation
    // which the core flags separately
    // the result never goes negative
    // so it feeds the scale subtraction directly

endmodule

// File: source/positAdder.sv
// posit adder top level with decoders, add/subtract core, encoder and output register
`timescale 1ns/1ns

module positAdder
(
    input  logic clk,
    input  logic reset,
    input  logic inValid,
    input  logic subtract,
    input  positConfigPkg::posit_t opA,
    input  positConfigPkg::posit_t opB,
    output logic outValid,
    output positConfigPkg::posit_t result
);
    import positConfigPkg::*;
    import positFieldsPkg::*;

    decodedPosit_t fieldsA;
    decodedPosit_t fieldsB;
    rawResult_t rawSum;
    posit_t encoded;

    ////////////////////////////////////////////////////////////
    // combinational datapath
    ////////////////////////////////////////////////////////////
    positDecoder decodeA (.operand(opA), .fields(fieldsA));
    positDecoder decodeB (.operand(opB), .fields(fieldsB));

    addSubtract core (.subtract(subtract), .a(fieldsA), .b(fieldsB), .raw(rawSum));

    positEncoder encode (.raw(rawSum), .posit(encoded));

    // one cycle latency, strobe tracks the data
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            outValid <= 1'b0;
            result <= '0;
        end
        else
        begin
            outValid <= inValid;
            result <= encoded;
        end
    end

endmodule

// File: source/positConfigPkg.sv
// posit format widths, saturation limit and the vector typedefs built on them
package positConfigPkg;

    // 16-bit posit with a single exponent bit
    localparam int positWidth = 16;
    localparam int expWidth = 1;

    // regime magnitude bits, one more bit for sign goes in regime_t
    localparam int regimeWidth = $clog2(positWidth);
    localparam int scaleWidth = regimeWidth + expWidth;

    // largest scale a posit can hold, maxpos is 2^maxScale
    localparam int maxScale = (positWidth - 2) << expWidth;

    ////////////////////////////////////////////////////////////
    // vector types
    ////////////////////////////////////////////////////////////
    typedef logic [positWidth-1:0] posit_t;
    typedef logic signed [regimeWidth:0] regime_t;
    typedef logic [expWidth-1:0] exponent_t;
    // hidden one sits at the msb
    typedef logic [positWidth-1:0] fraction_t;
    // extra headroom for the normalization shift
    typedef logic signed [scaleWidth+1:0] scale_t;
    // aligned sum, overflow bit on top
    typedef logic [2*positWidth:0] wideMant_t;

endpackage

// File: source/positDecoder.sv
// posit decoder producing sign, regime, exponent, fraction and zero/NaR flags
`timescale 1ns/1ns

module positDecoder
(
    input  positConfigPkg::posit_t operand,
    output positFieldsPkg::decodedPosit_t fields
);
    import positConfigPkg::*;

    // absolute value of the operand
    posit_t absBits;
    // bits left over once sign and regime are stripped
    posit_t afterRegime;
    // length of the regime run
    logic [regimeWidth:0] runLength;
    logic inRun;
    logic isZero;
    logic isNaR;

    assign isZero = (operand == '0);
    assign isNaR = (operand == {1'b1, {(positWidth-1){1'b0}}});

    // negative posits decode from their two's complement
    assign absBits = operand[positWidth-1] ? -operand : operand;

    ////////////////////////////////////////////////////////////
    // regime run length
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        runLength = '0;
        inRun = 1'b1;
        // count bits equal to the first regime bit
        for (int i = positWidth - 2; i >= 0; i--)
        begin
            if (inRun && (absBits[i] == absBits[positWidth-2]))
                runLength = runLength + 1'b1;
            else
                inRun = 1'b0;
        end
    end

    // skip sign, run and terminator, exponent lands at the msb
    assign afterRegime = absBits << (runLength + 2);

    always_comb
    begin
        fields.sign = operand[positWidth-1];
        // run of ones gives k = run - 1, run of zeros gives -run
        if (absBits[positWidth-2])
            fields.regime = regime_t'(runLength) - regime_t'(1);
        else
            fields.regime = -regime_t'(runLength);
        fields.exponent = afterRegime[positWidth-1 -: expWidth];
        // zero keeps an empty fraction so it drops out of the sum
        if (isZero)
            fields.fraction = '0;
        else
            fields.fraction = {1'b1, afterRegime[positWidth-expWidth-1:0]};
        fields.magnitude = absBits[positWidth-2:0];
        fields.isZero = isZero;
        fields.isNaR = isNaR;
    end

endmodule

// File: source/positEncoder.sv
// posit encoder with regime build, saturation and round to nearest even
`timescale 1ns/1ns

module positEncoder
(
    input  positFieldsPkg::rawResult_t raw,
    output positConfigPkg::posit_t posit
);
    import positConfigPkg::*;

    scale_t kWide;
    regime_t k;
    exponent_t expBits;
    logic [regimeWidth:0] runShift;
    // regime seed, exponent, fraction and zero pad for the shift
    logic signed [3*positWidth:0] work;
    logic [positWidth-2:0] truncated;
    logic [positWidth-2:0] rounded;
    logic guard;
    logic stickyAll;
    logic roundUp;

    ////////////////////////////////////////////////////////////
    // scale split and regime saturation
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        // floor divide keeps the exponent field non-negative
        kWide = raw.scale >>> expWidth;
        expBits = raw.scale[expWidth-1:0];
        // k above the top regime is beyond maxpos
        if (kWide > scale_t'(maxScale >> expWidth))
            k = regime_t'(maxScale >> expWidth);
        // one step below minpos still rounds, result forced to minpos later
        else if (kWide < -scale_t'((maxScale >> expWidth) + 1))
            k = -regime_t'((maxScale >> expWidth) + 1);
        else
            k = regime_t'(kWide);
    end

    ////////////////////////////////////////////////////////////
    // regime run by arithmetic shift
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        // negative k gives -k zeros then a one
        // ~k is -k - 1
        if (k[regimeWidth])
        begin
            runShift = ~k;
            work = $signed({2'b01, expBits, raw.mantissa[2*positWidth-2:0],
                            {(positWidth-1){1'b0}}});
        end
        else
        begin
            // k + 1 ones then a zero
            runShift = k;
            work = $signed({2'b10, expBits, raw.mantissa[2*positWidth-2:0],
                            {(positWidth-1){1'b0}}});
        end
        work = work >>> runShift;
    end

    ////////////////////////////////////////////////////////////
    // rounding and sign
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        truncated = work[3*positWidth -: positWidth-1];
        guard = work[2*positWidth+1];
        stickyAll = (|work[2*positWidth:0]) | raw.sticky;
        // halfway goes to even
        roundUp = guard & (stickyAll | truncated[0]);
        rounded = truncated + (positWidth-1)'(roundUp);
        // never round a nonzero result to zero
        if (rounded == '0)
            rounded = (positWidth-1)'(1);

        if (raw.isNaR)
            posit = {1'b1, {(positWidth-1){1'b0}}};
        else if (raw.isZero)
            posit = '0;
        else if (raw.sign)
            posit = -{1'b0, rounded};
        else
            posit = {1'b0, rounded};
    end

endmodule

// File: source/positFieldsPkg.sv
// decoded operand struct and raw add/subtract result struct
package positFieldsPkg;

    // one operand after field extraction
    typedef struct packed {
        logic sign;
        positConfigPkg::regime_t regime;
        positConfigPkg::exponent_t exponent;
        positConfigPkg::fraction_t fraction;
        // absolute bits without sign, orders like the value does
        logic [positConfigPkg::positWidth-2:0] magnitude;
        logic isZero;
        logic isNaR;
    } decodedPosit_t;

    // core output ahead of rounding
    typedef struct packed {
        logic sign;
        positConfigPkg::scale_t scale;
        // leading one at the msb
        logic [2*positConfigPkg::positWidth-1:0] mantissa;
        logic sticky;
        logic isZero;
        logic isNaR;
    } rawResult_t;

endpackage

// File: testbench/clockGen.sv
// clock source for the posit adder testbench
`timescale 1ns/1ns

module clockGen
(
    output logic clk
);

    // 10 ns period, starts low
    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

endmodule

// File: testbench/positAdderTb.sv
// posit adder testbench with stimulus, reference model, checks, watchdog and summary
`timescale 1ns/1ns

module positAdderTb;
    import positConfigPkg::*;

    localparam int resetCycles = 16;
    localparam int timingOps = 200;
    localparam int maxGap = 3;
    localparam int randomOps = 2000;
    localparam int directedOps = 64;
    // worst case cycles of every test, one drain per test, then the margin
    localparam int limitNs = (resetCycles + timingOps * (maxGap + 1) + 2 * randomOps
                             + directedOps + 5 * 4) * 10 + 500;

    // one issued operation and the result it should give
    typedef struct packed {
        posit_t opA;
        posit_t opB;
        logic subtract;
        posit_t expected;
    } pendingOp_t;

    logic clk;
    logic reset;
    logic inValid;
    logic subtract;
    posit_t opA;
    posit_t opB;
    logic outValid;
    posit_t result;

    pendingOp_t pending[$];
    pendingOp_t head;
    logic expectValid = 1'b0;
    logic [31:0] rngState;
    int errorCount = 0;
    int totalOps = 0;

    clockGen clockSource (.clk(clk));

    positAdder uut (.clk(clk), .reset(reset), .inValid(inValid), .subtract(subtract),
                    .opA(opA), .opB(opB), .outValid(outValid), .result(result));

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state ^ (state << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    ////////////////////////////////////////////////////////////
    // reference model, values held as integers scaled by 2^28
    ////////////////////////////////////////////////////////////
    function automatic longint posToFixed(input posit_t p);
        posit_t mag;
        logic lead;
        int i;
        int run;
        int k;
        int e;
        int fb;
        longint frac;
        longint value;
        if (p == '0)
            return 0;
        mag = p[15] ? -p : p;
        lead = mag[14];
        run = 0;
        i = 14;
        while (i >= 0 && mag[i] == lead)
        begin
            run++;
            i--;
        end
        // step over the terminating bit
        i--;
        k = lead ? run - 1 : -run;
        e = 0;
        if (i >= 0)
        begin
            e = int'(mag[i]);
            i--;
        end
        fb = 0;
        frac = 0;
        while (i >= 0)
        begin
            frac = (frac << 1) | longint'(mag[i]);
            fb++;
            i--;
        end
        value = ((longint'(1) << fb) + frac) << (28 + 2 * k + e - fb);
        return p[15] ? -value : value;
    endfunction

    function automatic posit_t fixedToPos(input longint value);
        logic neg;
        longint mag;
        int msb;
        int scale;
        int k;
        int pos;
        int j;
        logic [127:0] bits;
        logic [14:0] body;
        logic [15:0] rounded;
        if (value == 0)
            return '0;
        neg = value < 0;
        mag = neg ? -value : value;
        msb = 0;
        for (j = 0; j < 63; j++)
            if (mag[j])
                msb = j;
        scale = msb - 28;
        if (scale > 28)
            rounded = 16'h7fff;
        else
        begin
            k = scale >>> 1;
            // full bit string: regime run, terminator, exponent, every fraction bit
            bits = '0;
            pos = 127;
            for (j = 0; j < ((k >= 0) ? k + 1 : -k); j++)
            begin
                bits[pos] = (k >= 0);
                pos--;
            end
            bits[pos] = (k < 0);
            bits[pos-1] = scale[0];
            pos = pos - 2;
            for (j = msb - 1; j >= 0; j--)
            begin
                bits[pos] = mag[j];
                pos--;
            end
            body = bits[127:113];
            // nearest even on the encoding, guard at bit 112
            rounded = {1'b0, body} + 16'(bits[112] & ((|bits[111:0]) | body[0]));
            if (rounded > 16'h7fff)
                rounded = 16'h7fff;
            if (rounded == '0)
                rounded = 16'h0001;
        end
        return neg ? -rounded : rounded;
    endfunction

    function automatic posit_t modelResult(input posit_t a, input posit_t b, input logic sub);
        longint sum;
        if (a == 16'h8000 || b == 16'h8000)
            return 16'h8000;
        sum = sub ? posToFixed(a) - posToFixed(b) : posToFixed(a) + posToFixed(b);
        return fixedToPos(sum);
    endfunction

    ////////////////////////////////////////////////////////////
    // drive helpers
    ////////////////////////////////////////////////////////////
    task automatic issueOp(input posit_t a, input posit_t b, input logic sub, input posit_t exp);
        pendingOp_t entry;
        @(posedge clk);
        opA <= a;
        opB <= b;
        subtract <= sub;
        inValid <= 1'b1;
        entry.opA = a;
        entry.opB = b;
        entry.subtract = sub;
        entry.expected = exp;
        pending.push_back(entry);
        totalOps++;
    endtask

    task automatic idleCycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            inValid <= 1'b0;
        end
    endtask

    // stop issuing and wait for every result to come back
    task automatic drainPipeline();
        @(posedge clk);
        inValid <= 1'b0;
        while (pending.size() != 0)
            @(negedge clk);
    endtask

    task automatic reportTest(input string name, input int ops, input int mark);
        $display("test %s: %0d operations, %0d errors", name, ops, errorCount - mark);
    endtask

    // outputs settle by the falling edge
    always @(negedge clk)
    begin
        if (outValid !== expectValid)
        begin
            $display("[FAIL] outValid: got %h expected %h at %0t ns", outValid, expectValid, $time);
            errorCount++;
        end
        if (outValid === 1'b1)
        begin
            if (pending.size() == 0)
            begin
                $display("result marked valid at %0t ns with no operation pending", $time);
                errorCount++;
            end
            else
            begin
                head = pending.pop_front();
                if (result !== head.expected)
                begin
                    $display("[FAIL] result: got %h expected %h, opA %h opB %h subtract %0d",
                             result, head.expected, head.opA, head.opB, head.subtract);
                    errorCount++;
                end
            end
        end
        // next edge registers this input, reset wins
        expectValid = reset ? 1'b0 : inValid;
    end

    initial
    begin : watchdog
        #(limitNs);
        $display("watchdog timeout after %0d ns, results still outstanding", limitNs);
        $display("RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////
    initial
    begin : mainSequence
        int mark;
        int i;
        posit_t a;
        posit_t b;
        reset = 1'b1;
        inValid = 1'b0;
        subtract = 1'b0;
        opA = '0;
        opB = '0;
        rngState = 32'he5ee_a64e;

        // strobe toggles under reset, outValid must stay low
        mark = errorCount;
        repeat (resetCycles - 1)
        begin
            @(posedge clk);
            rngState = xorshift32(rngState);
            inValid <= rngState[0];
        end
        @(posedge clk);
        reset <= 1'b0;
        inValid <= 1'b0;
        for (i = 0; i < timingOps; i++)
        begin
            rngState = xorshift32(rngState);
            idleCycles(int'(rngState[17:16]));
            issueOp(rngState[15:0], rngState[31:16], rngState[18],
                    modelResult(rngState[15:0], rngState[31:16], rngState[18]));
        end
        drainPipeline();
        reportTest("timing and reset", timingOps, mark);

        mark = errorCount;
        for (i = 0; i < randomOps; i++)
        begin
            rngState = xorshift32(rngState);
            issueOp(rngState[15:0], rngState[31:16], 1'b0,
                    modelResult(rngState[15:0], rngState[31:16], 1'b0));
        end
        drainPipeline();
        reportTest("random addition", randomOps, mark);

        // half the pairs sit a few codes apart and cancel deeply
        mark = errorCount;
        for (i = 0; i < randomOps; i++)
        begin
            rngState = xorshift32(rngState);
            a = rngState[15:0];
            b = rngState[31] ? a + {{12{rngState[19]}}, rngState[19:16]} : rngState[31:16];
            issueOp(a, b, 1'b1, modelResult(a, b, 1'b1));
        end
        drainPipeline();
        reportTest("random subtraction", randomOps, mark);

        mark = errorCount;
        for (i = 0; i < 8; i++)
        begin
            rngState = xorshift32(rngState);
            a = (rngState[15:0] == 16'h8000) ? 16'h0001 : rngState[15:0];
            issueOp(16'h8000, a, rngState[16], 16'h8000);
            issueOp(a, 16'h8000, rngState[17], 16'h8000);
            issueOp(16'h0000, a, 1'b0, a);
            issueOp(a, 16'h0000, 1'b0, a);
            issueOp(a, a, 1'b1, 16'h0000);
        end
        drainPipeline();
        reportTest("special values", 40, mark);

        mark = errorCount;
        issueOp(16'h7fff, 16'h7fff, 1'b0, 16'h7fff);
        issueOp(16'h8001, 16'h8001, 1'b0, 16'h8001);
        // minpos minus the next code up stays nonzero
        issueOp(16'h0001, 16'h0002, 1'b1, 16'hfffe);
        // exact halfway with even and odd lower bits
        issueOp(16'h4000, 16'h00c0, 1'b0, 16'h4000);
        issueOp(16'h4001, 16'h00c0, 1'b0, 16'h4002);
        issueOp(16'hbfff, 16'hff40, 1'b0, 16'hbffe);
        drainPipeline();
        reportTest("saturation and rounding", 6, mark);

        $display("5 tests, %0d operations, %0d errors", totalOps, errorCount);
        if (errorCount == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: vlog.f
source/positConfigPkg.sv
source/positFieldsPkg.sv
source/positDecoder.sv
source/leadingBitDetector.sv
source/addSubtract.sv
source/positEncoder.sv
source/positAdder.sv
testbench/clockGen.sv
testbench/positAdderTb.sv
